/* hazard_config.svh */
`ifndef HAZARD_CONFIG_SVH
`define HAZARD_CONFIG_SVH

// architectural register count
`define HZ_NUM_REGS 32

// cycles a destination stays busy after issue
`define HZ_ALU_LAT 2
`define HZ_LOAD_LAT 3

// kill window after a taken branch
`define HZ_KILL_LEN 2

// countdown width, must hold HZ_LOAD_LAT
`define HZ_CNT_W 2

`endif

/* hazard_pkg.sv */
`include "hazard_config.svh"

package hazard_pkg;

	typedef logic [`HZ_CNT_W-1:0] cnt_t;

	// rv32i major opcodes handled at issue
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011
	} opcode_e;

	typedef enum logic [2:0] {
		unit_none   = 3'd0, // invalid word
		unit_upper  = 3'd1,
		unit_imm    = 3'd2,
		unit_branch = 3'd3,
		unit_load   = 3'd4,
		unit_store  = 3'd5,
		unit_reg    = 3'd6
	} unit_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// stores and branches share the split immediate layout
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} sb_fmt_t;

	typedef union packed {
		r_fmt_t  r;
		i_fmt_t  i;
		sb_fmt_t sb;
	} instr_u;

	typedef struct packed {
		logic       valid;
		unit_e      unit;
		logic [4:0] rs1;
		logic       use_rs1;
		logic [4:0] rs2;
		logic       use_rs2;
		logic [4:0] rd;
		logic       wr_rd; // never set for x0
	} decoded_t;

	typedef struct packed {
		logic stall;
		cnt_t stall_cycles;
		logic kill;
	} status_t;

	typedef struct packed {
		logic       valid;
		unit_e      unit;
		logic [4:0] rd;
	} issue_t;

endpackage

/* instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder (
	input  hazard_pkg::instr_u   instr,
	input  logic                 instr_valid,
	output hazard_pkg::decoded_t dec
);

	hazard_pkg::unit_e unit;

	// opcode is at the same bits in every view
	always_comb
	begin
		case (instr.r.opcode)
			hazard_pkg::opc_lui,
			hazard_pkg::opc_auipc,
			hazard_pkg::opc_jal:    unit = hazard_pkg::unit_upper;
			hazard_pkg::opc_jalr,
			hazard_pkg::opc_op_imm: unit = hazard_pkg::unit_imm;
			hazard_pkg::opc_branch: unit = hazard_pkg::unit_branch;
			hazard_pkg::opc_load:   unit = hazard_pkg::unit_load;
			hazard_pkg::opc_store:  unit = hazard_pkg::unit_store;
			hazard_pkg::opc_op:     unit = hazard_pkg::unit_reg;
			default:                unit = hazard_pkg::unit_none; // csr, fence, compressed
		endcase
	end

	always_comb
	begin
		dec = '0;
		dec.unit = instr_valid ? unit : hazard_pkg::unit_none;
		case (dec.unit)
			hazard_pkg::unit_upper:
			begin
				dec.valid = 1'b1;
				dec.rd = instr.i.rd;
				dec.wr_rd = 1'b1;
			end
			hazard_pkg::unit_imm, hazard_pkg::unit_load:
			begin
				dec.valid = 1'b1;
				dec.rs1 = instr.i.rs1;
				dec.use_rs1 = 1'b1;
				dec.rd = instr.i.rd;
				dec.wr_rd = 1'b1;
			end
			hazard_pkg::unit_branch, hazard_pkg::unit_store:
			begin
				dec.valid = 1'b1;
				dec.rs1 = instr.sb.rs1;
				dec.use_rs1 = 1'b1;
				dec.rs2 = instr.sb.rs2;
				dec.use_rs2 = 1'b1;
			end
			hazard_pkg::unit_reg:
			begin
				dec.valid = 1'b1;
				dec.rs1 = instr.r.rs1;
				dec.use_rs1 = 1'b1;
				dec.rs2 = instr.r.rs2;
				dec.use_rs2 = 1'b1;
				dec.rd = instr.r.rd;
				dec.wr_rd = 1'b1;
			end
			default:
			begin
				dec.valid = 1'b0;
			end
		endcase
		if (dec.rd == 5'd0)
			dec.wr_rd = 1'b0; // x0 writes are discarded
	end

endmodule

/* reg_scoreboard.sv */
`timescale 1ns/10ps
`include "hazard_config.svh"

module reg_scoreboard #(
	parameter int alu_lat  = `HZ_ALU_LAT,
	parameter int load_lat = `HZ_LOAD_LAT
) (
	input  logic                 clk,
	input  logic                 nrst,
	input  hazard_pkg::decoded_t dec,
	input  logic                 take,
	output logic                 raw_stall,
	output hazard_pkg::cnt_t     stall_cycles
);

	// cycles left until each register is written back
	hazard_pkg::cnt_t cnt [`HZ_NUM_REGS];
	hazard_pkg::cnt_t lat;
	hazard_pkg::cnt_t left1;
	hazard_pkg::cnt_t left2;
	logic             reserve;

	assign reserve = take && dec.wr_rd && (dec.rd != 5'd0);

	always_comb
	begin
		if (dec.unit == hazard_pkg::unit_load)
			lat = hazard_pkg::cnt_t'(load_lat);
		else
			lat = hazard_pkg::cnt_t'(alu_lat);
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < `HZ_NUM_REGS; i++)
				cnt[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < `HZ_NUM_REGS; i++)
			begin
				// a new reservation overrides whatever is pending
				if (reserve && dec.rd == 5'(i))
					cnt[i] <= lat;
				else if (cnt[i] != '0)
					cnt[i] <= cnt[i] - 1'b1;
			end
		end
	end

	// unused sources never stall
	assign left1 = dec.use_rs1 ? cnt[dec.rs1] : '0;
	assign left2 = dec.use_rs2 ? cnt[dec.rs2] : '0;

	assign raw_stall = (left1 != '0) || (left2 != '0);

	// larger of the two, zero when nothing is pending
	assign stall_cycles = (left1 > left2) ? left1 : left2;

endmodule

/* issue_control.sv */
`timescale 1ns/10ps
`include "hazard_config.svh"

module issue_control #(
	parameter int kill_len = `HZ_KILL_LEN
) (
	input  logic                 clk,
	input  logic                 nrst,
	input  logic                 btaken,
	input  hazard_pkg::decoded_t dec,
	input  logic                 raw_stall,
	input  hazard_pkg::cnt_t     stall_cycles,
	output logic                 take,
	output hazard_pkg::status_t  status,
	output hazard_pkg::issue_t   issued
);

	localparam int kill_w = $clog2(kill_len + 1);

	logic [kill_w-1:0] kill_cnt;
	logic              kill;

	// btaken restarts the window even mid-kill
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			kill_cnt <= '0;
		else if (btaken)
			kill_cnt <= kill_w'(kill_len);
		else if (kill_cnt != '0)
			kill_cnt <= kill_cnt - 1'b1;
	end

	assign kill = (kill_cnt != '0);

	// wrong-path words are dropped, not held
	assign take = dec.valid && !raw_stall && !kill;

	always_comb
	begin
		status.stall = raw_stall && !kill;
		status.stall_cycles = kill ? '0 : stall_cycles; // hidden under kill
		status.kill = kill;
	end

	always_comb
	begin
		issued.valid = take;
		issued.unit = take ? dec.unit : hazard_pkg::unit_none;
		issued.rd = take ? dec.rd : 5'd0;
	end

endmodule

/* hazard_unit.sv */
`timescale 1ns/10ps

module hazard_unit (
	input  logic                clk,
	input  logic                nrst,
	input  hazard_pkg::instr_u  instr,
	input  logic                instr_valid,
	input  logic                btaken,
	output hazard_pkg::status_t status,
	output hazard_pkg::issue_t  issued
);

	hazard_pkg::decoded_t dec;
	hazard_pkg::cnt_t     stall_cycles;
	logic                 raw_stall;
	logic                 take; // reserve rd this cycle

	instr_decoder instr_decoder_i (
		.instr       (instr),
		.instr_valid (instr_valid),
		.dec         (dec)
	);

	reg_scoreboard reg_scoreboard_i (
		.clk          (clk),
		.nrst         (nrst),
		.dec          (dec),
		.take         (take),
		.raw_stall    (raw_stall),
		.stall_cycles (stall_cycles)
	);

	issue_control issue_control_i (
		.clk          (clk),
		.nrst         (nrst),
		.btaken       (btaken),
		.dec          (dec),
		.raw_stall    (raw_stall),
		.stall_cycles (stall_cycles),
		.take         (take),
		.status       (status),
		.issued       (issued)
	);

endmodule

/* hazard_unit_checker.sv */
`timescale 1ns/10ps

module hazard_unit_checker (
	input logic                clk,
	input logic                nrst,
	input hazard_pkg::status_t status,
	input hazard_pkg::issue_t  issued
);

	no_stall_issue: assert property (@(posedge clk) disable iff (!nrst)
		!(status.stall && issued.valid))
		else $error("stall and issue in the same cycle");

	no_issue_in_kill: assert property (@(posedge clk) disable iff (!nrst)
		status.kill |-> !issued.valid)
		else $error("instruction issued during kill");

	cycles_need_stall: assert property (@(posedge clk) disable iff (!nrst)
		!status.stall |-> status.stall_cycles == '0)
		else $error("stall_cycles nonzero without a stall");

	// first edge out of reset
	no_kill_after_reset: assert property (@(posedge clk) $rose(nrst) |-> !status.kill)
		else $error("kill high right after reset");

endmodule

bind hazard_unit hazard_unit_checker hazard_unit_checker_i (
	.clk    (clk),
	.nrst   (nrst),
	.status (status),
	.issued (issued)
);

/* hazard_unit_tb.sv */
`timescale 1ns/10ps

module hazard_unit_tb;

	typedef struct packed {
		int                  grp;
		hazard_pkg::instr_u  instr;
		logic                instr_valid;
		logic                btaken;
		hazard_pkg::status_t status;
		hazard_pkg::issue_t  issued;
	} row_t;

	localparam int reset_cycles = 2;

	logic                clk;
	logic                nrst;
	hazard_pkg::instr_u  instr;
	logic                instr_valid;
	logic                btaken;
	hazard_pkg::status_t status;
	hazard_pkg::issue_t  issued;

	row_t rows[$]; // one row per cycle
	int   cycles;
	int   limit;
	int   pass_cnt;
	int   fail_cnt;
	int   grp_errs;

	hazard_unit hazard_unit_i (.*);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > limit)
		begin
			$display("timeout: table still running after %0d cycles", limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// rd slot is imm_lo for stores and branches
	function automatic hazard_pkg::instr_u encode(logic [6:0] op, int rd, int rs1, int rs2);
		return {7'd0, 5'(rs2), 5'(rs1), 3'd0, 5'(rd), op};
	endfunction

	task automatic check_status(input hazard_pkg::status_t got, input hazard_pkg::status_t exp);
		if (got === exp)
			pass_cnt++;
		else
		begin
			fail_cnt++;
			grp_errs++;
			$display("Fail at %0t: status stall/cycles/kill %b/%0d/%b, expected %b/%0d/%b",
				$time, got.stall, got.stall_cycles, got.kill,
				exp.stall, exp.stall_cycles, exp.kill);
		end
	endtask

	task automatic check_issue(input hazard_pkg::issue_t got, input hazard_pkg::issue_t exp);
		if (got === exp)
			pass_cnt++;
		else
		begin
			fail_cnt++;
			grp_errs++;
			$display("Fail at %0t: issued valid/unit/rd %b/%0d/%0d, expected %b/%0d/%0d",
				$time, got.valid, got.unit, got.rd, exp.valid, exp.unit, exp.rd);
		end
	endtask

	task automatic add_row(input int grp, input hazard_pkg::instr_u w, input int v, input int bt,
		input int stall, input int cyc, input int kill, input hazard_pkg::unit_e u, input int rd);
		row_t r;
		r.grp = grp;
		r.instr = w;
		r.instr_valid = 1'(v);
		r.btaken = 1'(bt);
		r.status.stall = 1'(stall);
		r.status.stall_cycles = hazard_pkg::cnt_t'(cyc);
		r.status.kill = 1'(kill);
		r.issued.valid = (u != hazard_pkg::unit_none);
		r.issued.unit = u;
		r.issued.rd = 5'(rd);
		rows.push_back(r);
	endtask

	task automatic go(input int grp, input hazard_pkg::instr_u w, input int bt,
		input hazard_pkg::unit_e u, input int rd);
		add_row(grp, w, 1, bt, 0, 0, 0, u, rd);
	endtask

	task automatic held(input int grp, input hazard_pkg::instr_u w, input int cyc);
		add_row(grp, w, 1, 0, 1, cyc, 0, hazard_pkg::unit_none, 0);
	endtask

	task automatic killed(input int grp, input hazard_pkg::instr_u w, input int bt);
		add_row(grp, w, 1, bt, 0, 0, 1, hazard_pkg::unit_none, 0);
	endtask

	initial
	begin
		clk = 1'b0;
		nrst = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		btaken = 1'b0;
		cycles = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		grp_errs = 0;
		// every class back to back, then x0 and invalid words
		go(1, encode(hazard_pkg::opc_lui, 1, 0, 0), 0, hazard_pkg::unit_upper, 1);
		go(1, encode(hazard_pkg::opc_jalr, 4, 10, 0), 0, hazard_pkg::unit_imm, 4);
		go(1, encode(hazard_pkg::opc_load, 5, 11, 0), 0, hazard_pkg::unit_load, 5);
		go(1, encode(hazard_pkg::opc_store, 9, 12, 13), 0, hazard_pkg::unit_store, 0);
		go(1, encode(hazard_pkg::opc_branch, 8, 14, 15), 0, hazard_pkg::unit_branch, 0);
		go(1, encode(hazard_pkg::opc_op, 0, 9, 8), 0, hazard_pkg::unit_reg, 0);
		go(1, encode(hazard_pkg::opc_op_imm, 7, 0, 0), 0, hazard_pkg::unit_imm, 7);
		add_row(1, encode(7'b1110011, 1, 2, 0), 1, 0, 0, 0, 0, hazard_pkg::unit_none, 0); // csr
		add_row(1, encode(hazard_pkg::opc_op, 3, 1, 2), 0, 0, 0, 0, 0,
			hazard_pkg::unit_none, 0); // instr_valid low
		go(2, encode(hazard_pkg::opc_op, 20, 1, 2), 0, hazard_pkg::unit_reg, 20);
		held(2, encode(hazard_pkg::opc_op_imm, 21, 20, 0), 2);
		held(2, encode(hazard_pkg::opc_op_imm, 21, 20, 0), 1);
		go(2, encode(hazard_pkg::opc_op_imm, 21, 20, 0), 0, hazard_pkg::unit_imm, 21);
		go(2, encode(hazard_pkg::opc_op, 22, 1, 2), 0, hazard_pkg::unit_reg, 22);
		go(2, encode(hazard_pkg::opc_op_imm, 23, 1, 0), 0, hazard_pkg::unit_imm, 23);
		held(2, encode(hazard_pkg::opc_op_imm, 24, 22, 0), 1); // two behind
		go(2, encode(hazard_pkg::opc_op_imm, 24, 22, 0), 0, hazard_pkg::unit_imm, 24);
		go(3, encode(hazard_pkg::opc_load, 25, 1, 0), 0, hazard_pkg::unit_load, 25);
		held(3, encode(hazard_pkg::opc_op_imm, 26, 25, 0), 3);
		held(3, encode(hazard_pkg::opc_op_imm, 26, 25, 0), 2);
		held(3, encode(hazard_pkg::opc_op_imm, 26, 25, 0), 1);
		go(3, encode(hazard_pkg::opc_op_imm, 26, 25, 0), 0, hazard_pkg::unit_imm, 26);
		go(4, encode(hazard_pkg::opc_op, 28, 1, 2), 0, hazard_pkg::unit_reg, 28);
		go(4, encode(hazard_pkg::opc_load, 27, 1, 0), 0, hazard_pkg::unit_load, 27);
		held(4, encode(hazard_pkg::opc_store, 0, 28, 27), 3); // rs1 has 1 left
		held(4, encode(hazard_pkg::opc_store, 0, 28, 27), 2);
		held(4, encode(hazard_pkg::opc_store, 0, 28, 27), 1);
		go(4, encode(hazard_pkg::opc_store, 0, 28, 27), 0, hazard_pkg::unit_store, 0);
		// load issues with the branch pulse, its reader sits under the kill
		go(5, encode(hazard_pkg::opc_load, 10, 2, 0), 1, hazard_pkg::unit_load, 10);
		killed(5, encode(hazard_pkg::opc_op_imm, 11, 10, 0), 0);
		killed(5, encode(hazard_pkg::opc_op_imm, 29, 1, 0), 0);
		held(5, encode(hazard_pkg::opc_op, 11, 10, 29), 1); // x29 never reserved
		go(5, encode(hazard_pkg::opc_op, 11, 10, 29), 0, hazard_pkg::unit_reg, 11);
		limit = rows.size() + reset_cycles + 20;
		repeat (reset_cycles) @(posedge clk);
		nrst <= 1'b1;
		foreach (rows[k])
		begin
			@(posedge clk);
			instr <= rows[k].instr;
			instr_valid <= rows[k].instr_valid;
			btaken <= rows[k].btaken;
			@(negedge clk);
			check_status(status, rows[k].status);
			check_issue(issued, rows[k].issued);
			if (k == rows.size() - 1 || rows[k + 1].grp != rows[k].grp)
			begin
				$display("group %0d %s with %0d errors", rows[k].grp,
					grp_errs == 0 ? "passed" : "failed", grp_errs);
				grp_errs = 0;
			end
		end
		$display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* sim.f */
+incdir+.
hazard_pkg.sv
instr_decoder.sv
reg_scoreboard.sv
issue_control.sv
hazard_unit.sv
hazard_unit_checker.sv
hazard_unit_tb.sv

/* Makefile */
# Verilator simulation of the hazard unit
VERILATOR ?= verilator
TOP       ?= hazard_unit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
